/* qspim_pkg.sv */
//--------------------------------------------------------------------------
// Shared definitions for the quad-SPI register and control block
// Register map, phase sequence codes, flash commands and packed structs
// for the port config, transfer descriptor and command FIFO word
//--------------------------------------------------------------------------
`default_nettype none

package qspim_pkg;

  typedef logic [31:0] reg_data_t;  // Register data word
  typedef logic [3:0]  reg_addr_t;  // Register index
  typedef logic [3:0]  reg_be_t;    // Byte enables

  // Register map
  typedef enum logic [3:0] {
    GLBL_CTRL  = 4'd0,
    DMEM_CTRL1 = 4'd1,
    DMEM_CTRL2 = 4'd2,
    IMEM_CTRL1 = 4'd3,
    IMEM_CTRL2 = 4'd4,
    IMEM_ADDR  = 4'd5,
    IMEM_WDATA = 4'd6,
    IMEM_RDATA = 4'd7,
    SPI_STATUS = 4'd8
  } reg_addr_e;

  // Phase sequences, C = command, A = address, M = mode, D = dummy
  typedef enum logic [3:0] {
    SEQ_C, SEQ_CW, SEQ_CA, SEQ_CAR, SEQ_CADR, SEQ_CAMR,
    SEQ_CAMDR, SEQ_CAW, SEQ_CADW, SEQ_CDR, SEQ_CDW, SEQ_CR
  } spi_seq_e;

  typedef enum logic [1:0] {MODE_SINGLE, MODE_DOUBLE, MODE_QUAD} spi_mode_e;
  typedef enum logic [1:0] {MSW_IDLE, MSW_AT_ADDR, MSW_AT_DATA} mode_switch_e;
  typedef enum logic [1:0] {BITS_8, BITS_16, BITS_24, BITS_32} byte_cnt_e;

  // Flash commands
  localparam logic [7:0] CMD_QOR  = 8'h6B;  // Quad output read
  localparam logic [7:0] CMD_QIOR = 8'hEB;  // Quad I/O read
  localparam logic [7:0] CMD_RES  = 8'hAB;  // Release from power down
  localparam logic [7:0] CMD_WEN  = 8'h06;  // Write enable
  localparam logic [7:0] CMD_WRR  = 8'h01;  // Write status/config

  localparam logic [3:0] CS0 = 4'b0001;     // Chip select 0, one-hot

  // CR1 bit 1 set enables quad mode
  localparam logic [31:0] WRR_CFG_WORD = 32'h0000_0200;

  // Low byte of the CTRL1 registers
  typedef struct packed {
    mode_switch_e sw;
    spi_mode_e    mode;
    logic [3:0]   cs;
  } port_cfg_t;

  // CTRL2 layout, also the command header payload
  typedef struct packed {
    logic [7:0] data_cnt;   // Bytes
    byte_cnt_e  dummy_cnt;
    byte_cnt_e  addr_cnt;
    spi_seq_e   seq;
    logic [7:0] mode;
    logic [7:0] cmd;
  } xfer_desc_t;

  typedef struct packed {
    logic      soc;      // Start of command
    logic      eoc;      // End of command
    reg_data_t payload;
  } cmd_word_t;

  typedef enum logic [2:0] {
    INIT_PWUP, INIT_IDLE, INIT_CMD_WAIT, INIT_WREN_CMD,
    INIT_WREN_WAIT, INIT_WRR_CMD, INIT_WRR_WAIT, INIT_WAIT
  } init_fsm_e;

  typedef enum logic [2:0] {
    IND_IDLE, IND_ADR_PHASE, IND_WRITE_PHASE, IND_READ_PHASE,
    IND_READ_BUSY, IND_WRITE_BUSY, IND_ACK_PHASE
  } ind_fsm_e;

endpackage

`default_nettype wire

/* qspim_init_seq.sv */
//--------------------------------------------------------------------------
// Power-up init sequencer
// Waits INIT_DELAY cycles, issues RES, WREN and WRR (quad enable) on the
// indirect path, waits again and then flags init done
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module qspim_init_seq import qspim_pkg::*; #(
  parameter int INIT_DELAY = 1000
) (
  input  logic       mclk,
  input  logic       rst_n,
  input  logic       ind_done,   // Sequencer finished a transfer
  output logic       init_req,   // Held until ind_done
  output logic       init_load,  // Descriptor strobe
  output xfer_desc_t init_desc,
  output logic       init_done
);

  localparam int DLY_W = $clog2(INIT_DELAY + 1);

  init_fsm_e        state;
  logic [DLY_W-1:0] dly_cnt;
  logic             dly_done;

  assign dly_done = (dly_cnt == DLY_W'(INIT_DELAY));

  // Descriptor per command state, each state lasts one cycle
  always_comb begin
    init_desc = '0;
    init_load = 1'b1;
    case (state)
      INIT_IDLE: begin
        init_desc.cmd = CMD_RES;
        init_desc.seq = SEQ_C;
      end
      INIT_WREN_CMD: begin
        init_desc.cmd = CMD_WEN;
        init_desc.seq = SEQ_C;
      end
      INIT_WRR_CMD: begin
        init_desc.cmd      = CMD_WRR;
        init_desc.seq      = SEQ_CW;
        init_desc.data_cnt = 8'd2;  // SR1 + CR1
      end
      default: init_load = 1'b0;
    endcase
  end

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      state     <= INIT_PWUP;
      dly_cnt   <= '0;
      init_req  <= 1'b0;
      init_done <= 1'b0;
    end else begin
      case (state)
        // Flash needs some microseconds after power up
        INIT_PWUP: begin
          if (dly_done) state <= INIT_IDLE;
          else dly_cnt <= dly_cnt + 1'b1;
        end
        INIT_IDLE: begin
          init_req <= 1'b1;
          state    <= INIT_CMD_WAIT;
        end
        INIT_CMD_WAIT: begin
          if (ind_done) begin
            init_req <= 1'b0;
            state    <= INIT_WREN_CMD;
          end
        end
        INIT_WREN_CMD: begin
          init_req <= 1'b1;
          state    <= INIT_WREN_WAIT;
        end
        INIT_WREN_WAIT: begin
          if (ind_done) begin
            init_req <= 1'b0;
            state    <= INIT_WRR_CMD;
          end
        end
        INIT_WRR_CMD: begin
          init_req <= 1'b1;
          state    <= INIT_WRR_WAIT;
        end
        INIT_WRR_WAIT: begin
          if (ind_done) begin
            init_req <= 1'b0;
            dly_cnt  <= '0;      // Restart for the WRR settle time
            state    <= INIT_WAIT;
          end
        end
        default: begin          // INIT_WAIT, parks here once done
          if (dly_done) init_done <= 1'b1;
          else dly_cnt <= dly_cnt + 1'b1;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* qspim_cfg_regs.sv */
//--------------------------------------------------------------------------
// Register file of the quad-SPI controller
// Byte-enabled writes, read mux, registered ack and decode of the
// indirect data requests towards the sequencer
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module qspim_cfg_regs import qspim_pkg::*; (
  input  logic       mclk,
  input  logic       rst_n,
  // Register bus
  input  logic       reg_req,
  input  logic       reg_we,
  input  reg_addr_t  reg_addr,
  input  reg_be_t    reg_be,
  input  reg_data_t  reg_wdata,
  output logic       reg_ack,
  output reg_data_t  reg_rdata,
  input  reg_data_t  spi_status,
  // Init sequencer
  input  logic       init_done,
  input  logic       init_load,
  input  xfer_desc_t init_desc,
  // Indirect sequencer
  input  logic       ind_wrdy,
  input  logic       ind_rrdy,
  input  reg_data_t  ind_rdata,
  output logic       ind_rd_req,
  output logic       ind_wr_req,
  output logic       ind_fsm_reset,
  output xfer_desc_t m1_desc,
  output port_cfg_t  m1_port,
  output reg_data_t  m1_addr,
  output reg_data_t  m1_wdata,
  // Direct-read config
  output xfer_desc_t m0_desc,
  output port_cfg_t  m0_port,
  output logic       m0_fsm_reset,
  output logic [1:0] cs_early,
  output logic [1:0] cs_late,
  output logic [7:0] spi_clk_div
);

  logic      plain_req;  // Request eligible for service this cycle
  logic      is_wd;      // Write to IMEM_WDATA
  logic      is_rd;      // Read of IMEM_RDATA
  logic      ack_set;
  logic      reg_wr;
  reg_data_t rd_mux;
  reg_data_t wr_word;    // Addressed register with enabled bytes replaced

  //------------------------------------------------------------------------
  // Request decode and ack
  //------------------------------------------------------------------------
  assign plain_req  = reg_req && init_done && !reg_ack;  // Blank during ack
  assign is_wd      = reg_we && (reg_addr == IMEM_WDATA);
  assign is_rd      = !reg_we && (reg_addr == IMEM_RDATA);
  assign ind_wr_req = plain_req && is_wd;
  assign ind_rd_req = plain_req && is_rd;
  assign reg_wr     = plain_req && reg_we;

  // FIFO data accesses wait on the sequencer strobes
  assign ack_set = plain_req && (is_wd ? ind_wrdy : (is_rd ? ind_rrdy : 1'b1));

  always_ff @(posedge mclk) begin
    if (!rst_n) reg_ack <= 1'b0;
    else reg_ack <= ack_set;  // Self clears, gated by !reg_ack
  end

  always_ff @(posedge mclk) begin
    if (ack_set) reg_rdata <= rd_mux;
  end

  //------------------------------------------------------------------------
  // Read mux and byte merge
  //------------------------------------------------------------------------
  always_comb begin
    case (reg_addr)
      GLBL_CTRL:  rd_mux = {16'h0, spi_clk_div, 4'h0, cs_late, cs_early};
      DMEM_CTRL1: rd_mux = {23'h0, m0_fsm_reset, m0_port};
      DMEM_CTRL2: rd_mux = m0_desc;
      IMEM_CTRL1: rd_mux = {23'h0, ind_fsm_reset, m1_port};
      IMEM_CTRL2: rd_mux = m1_desc;
      IMEM_ADDR:  rd_mux = m1_addr;
      IMEM_WDATA: rd_mux = m1_wdata;
      IMEM_RDATA: rd_mux = ind_rdata;  // Valid with ind_rrdy
      SPI_STATUS: rd_mux = spi_status;
      default:    rd_mux = '0;
    endcase
  end

  always_comb begin
    wr_word = rd_mux;
    for (int i = 0; i < 4; i++) begin
      if (reg_be[i]) wr_word[i*8 +: 8] = reg_wdata[i*8 +: 8];
    end
  end

  //------------------------------------------------------------------------
  // Register update
  //------------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      m0_fsm_reset  <= 1'b0;
      m0_port       <= '{sw: MSW_AT_ADDR, mode: MODE_QUAD, cs: CS0};
      m0_desc       <= '{data_cnt: 8'd32, dummy_cnt: BITS_16, addr_cnt: BITS_24,
                         seq: SEQ_CAMDR, mode: 8'h00, cmd: CMD_QIOR};
      ind_fsm_reset <= 1'b0;
      m1_port       <= '{sw: MSW_AT_DATA, mode: MODE_QUAD, cs: CS0};
      m1_desc       <= '{data_cnt: 8'd0, dummy_cnt: BITS_8, addr_cnt: BITS_24,
                         seq: SEQ_CADR, mode: 8'h00, cmd: CMD_QOR};
      m1_addr       <= '0;
      m1_wdata      <= '0;
      cs_early      <= 2'd1;
      cs_late       <= 2'd1;
      spi_clk_div   <= 8'd2;
    end else if (init_load) begin
      // Init commands go out single lane on CS0
      m1_desc  <= init_desc;
      m1_port  <= '{sw: MSW_IDLE, mode: MODE_SINGLE, cs: CS0};
      m1_wdata <= WRR_CFG_WORD;
    end else if (reg_wr) begin
      case (reg_addr)
        GLBL_CTRL: begin
          cs_early    <= wr_word[1:0];
          cs_late     <= wr_word[3:2];
          spi_clk_div <= wr_word[15:8];
        end
        DMEM_CTRL1: begin
          m0_port      <= port_cfg_t'(wr_word[7:0]);
          m0_fsm_reset <= wr_word[8];
        end
        DMEM_CTRL2: m0_desc <= xfer_desc_t'(wr_word);
        IMEM_CTRL1: begin
          m1_port       <= port_cfg_t'(wr_word[7:0]);
          ind_fsm_reset <= wr_word[8];  // Soft reset of the sequencer
        end
        IMEM_CTRL2: m1_desc  <= xfer_desc_t'(wr_word);
        IMEM_ADDR:  m1_addr  <= wr_word;
        IMEM_WDATA: m1_wdata <= wr_word;  // Readback copy
        default: ;                        // Read-only or unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

/* qspim_ind_fsm.sv */
//--------------------------------------------------------------------------
// Indirect transfer sequencer
// Builds header, address and data words for the command FIFO and pops
// read data from the response FIFO
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module qspim_ind_fsm import qspim_pkg::*; (
  input  logic       mclk,
  input  logic       rst_n,
  input  logic       ind_fsm_reset,   // Soft reset, holds IDLE
  input  logic       init_req,
  input  logic       ind_rd_req,
  input  logic       ind_wr_req,
  input  xfer_desc_t m1_desc,
  input  reg_data_t  m1_addr,
  input  reg_data_t  m1_wdata,
  input  reg_data_t  reg_wdata,
  // Command FIFO
  input  logic       cmd_fifo_full,
  input  logic       cmd_fifo_empty,
  output logic       cmd_fifo_wr,
  output cmd_word_t  cmd_fifo_wdata,
  // Response FIFO
  input  logic       res_fifo_empty,
  input  reg_data_t  res_fifo_rdata,
  output logic       res_fifo_rd,
  // Back to registers and init
  output logic       ind_wrdy,
  output logic       ind_rrdy,
  output reg_data_t  ind_rdata,
  output logic       ind_done
);

  ind_fsm_e   state;
  ind_fsm_e   next_state;
  logic [5:0] cnt;        // Data word index
  logic [5:0] next_cnt;
  logic [7:0] data_m1;    // Byte count minus one
  logic       last_word;
  logic       xfer_req;
  logic       wr_src;     // Write data available
  reg_data_t  wr_data;

  assign data_m1   = m1_desc.data_cnt - 8'd1;
  assign last_word = (cnt == data_m1[7:2]);  // ceil(count / 4) words
  assign xfer_req  = init_req || ind_rd_req || ind_wr_req;
  assign wr_src    = init_req || ind_wr_req;
  assign wr_data   = init_req ? m1_wdata : reg_wdata;
  assign ind_rdata = res_fifo_rdata;         // Qualified by ind_rrdy

  always_ff @(posedge mclk) begin
    if (!rst_n || ind_fsm_reset) begin
      state <= IND_IDLE;
      cnt   <= '0;
    end else begin
      state <= next_state;
      cnt   <= next_cnt;
    end
  end

  always_comb begin
    next_state     = state;
    next_cnt       = cnt;
    cmd_fifo_wr    = 1'b0;
    cmd_fifo_wdata = '{soc: 1'b0, eoc: 1'b0, payload: m1_addr};
    res_fifo_rd    = 1'b0;
    ind_wrdy       = 1'b0;
    ind_rrdy       = 1'b0;
    ind_done       = 1'b0;
    if (!ind_fsm_reset) begin
      case (state)
        // Header goes out only into an empty FIFO
        IND_IDLE: begin
          next_cnt = '0;
          if (xfer_req && cmd_fifo_empty && !cmd_fifo_full) begin
            cmd_fifo_wr    = 1'b1;
            cmd_fifo_wdata = '{soc: 1'b1, eoc: 1'b0, payload: m1_desc};
            case (m1_desc.seq)
              SEQ_C: begin
                cmd_fifo_wdata.eoc = 1'b1;
                ind_wrdy           = 1'b1;
                next_state         = IND_ACK_PHASE;
              end
              SEQ_CW, SEQ_CDW: next_state = IND_WRITE_PHASE;
              SEQ_CDR, SEQ_CR: begin
                cmd_fifo_wdata.eoc = 1'b1;
                next_state         = IND_READ_PHASE;
              end
              default: next_state = IND_ADR_PHASE;
            endcase
          end
        end
        IND_ADR_PHASE: begin
          if (!cmd_fifo_full) begin
            cmd_fifo_wr = 1'b1;
            case (m1_desc.seq)
              SEQ_CA: begin
                cmd_fifo_wdata.eoc = 1'b1;
                ind_wrdy           = 1'b1;
                next_state         = IND_ACK_PHASE;
              end
              SEQ_CAW, SEQ_CADW: next_state = IND_WRITE_PHASE;
              default: begin                // Address then read data
                cmd_fifo_wdata.eoc = 1'b1;
                next_state         = IND_READ_PHASE;
              end
            endcase
          end
        end
        IND_READ_PHASE: begin
          if (!res_fifo_empty && ind_rd_req) begin
            ind_rrdy    = 1'b1;
            res_fifo_rd = 1'b1;
            next_state  = last_word ? IND_ACK_PHASE : IND_READ_BUSY;
            next_cnt    = cnt + 1'b1;
          end
        end
        IND_READ_BUSY: if (!ind_rd_req) next_state = IND_READ_PHASE;  // Wait req drop
        IND_WRITE_PHASE: begin
          if (!cmd_fifo_full && wr_src) begin
            ind_wrdy       = 1'b1;
            cmd_fifo_wr    = 1'b1;
            cmd_fifo_wdata = '{soc: 1'b0, eoc: last_word, payload: wr_data};
            next_state     = last_word ? IND_ACK_PHASE : IND_WRITE_BUSY;
            next_cnt       = cnt + 1'b1;
          end
        end
        IND_WRITE_BUSY: if (!ind_wr_req) next_state = IND_WRITE_PHASE;
        default: begin                      // IND_ACK_PHASE
          ind_done   = 1'b1;
          next_state = IND_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* qspim_regs.sv */
//--------------------------------------------------------------------------
// Register and control top level of the quad-SPI flash controller
// Init sequencer, register file and indirect transfer sequencer
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module qspim_regs import qspim_pkg::*; #(
  parameter int INIT_DELAY = 1000     // Cycles per init wait
) (
  input  logic       mclk,
  input  logic       rst_n,
  // Register bus
  input  logic       reg_req,
  input  reg_addr_t  reg_addr,
  input  logic       reg_we,
  input  reg_be_t    reg_be,
  input  reg_data_t  reg_wdata,
  output logic       reg_ack,
  output reg_data_t  reg_rdata,
  // Status and init
  input  reg_data_t  spi_status,
  output logic       init_done,
  // Command FIFO
  input  logic       cmd_fifo_full,
  input  logic       cmd_fifo_empty,
  output logic       cmd_fifo_wr,
  output cmd_word_t  cmd_fifo_wdata,
  // Response FIFO
  input  logic       res_fifo_empty,
  output logic       res_fifo_rd,
  input  reg_data_t  res_fifo_rdata,
  // Configuration for the SPI engines
  output xfer_desc_t m0_desc,
  output port_cfg_t  m0_port,
  output logic       m0_fsm_reset,
  output port_cfg_t  m1_port,
  output logic [1:0] cs_early,
  output logic [1:0] cs_late,
  output logic [7:0] spi_clk_div
);

  logic       ind_done;
  logic       init_req;
  logic       init_load;
  xfer_desc_t init_desc;
  logic       ind_wrdy;
  logic       ind_rrdy;
  reg_data_t  ind_rdata;
  logic       ind_rd_req;
  logic       ind_wr_req;
  logic       ind_fsm_reset;
  xfer_desc_t m1_desc;
  reg_data_t  m1_addr;
  reg_data_t  m1_wdata;

  qspim_init_seq #(.INIT_DELAY(INIT_DELAY)) u_init_seq (
    .mclk, .rst_n, .ind_done, .init_req, .init_load, .init_desc, .init_done
  );

  qspim_cfg_regs u_cfg_regs (
    .mclk, .rst_n,
    .reg_req, .reg_we, .reg_addr, .reg_be, .reg_wdata, .reg_ack, .reg_rdata,
    .spi_status, .init_done, .init_load, .init_desc,
    .ind_wrdy, .ind_rrdy, .ind_rdata, .ind_rd_req, .ind_wr_req, .ind_fsm_reset,
    .m1_desc, .m1_port, .m1_addr, .m1_wdata,
    .m0_desc, .m0_port, .m0_fsm_reset, .cs_early, .cs_late, .spi_clk_div
  );

  qspim_ind_fsm u_ind_fsm (
    .mclk, .rst_n, .ind_fsm_reset, .init_req, .ind_rd_req, .ind_wr_req,
    .m1_desc, .m1_addr, .m1_wdata, .reg_wdata,
    .cmd_fifo_full, .cmd_fifo_empty, .cmd_fifo_wr, .cmd_fifo_wdata,
    .res_fifo_empty, .res_fifo_rdata, .res_fifo_rd,
    .ind_wrdy, .ind_rrdy, .ind_rdata, .ind_done
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
//--------------------------------------------------------------------------
// Testbench clock source, free running from time zero
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 100  // ns
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* qspim_regs_chk.sv */
//--------------------------------------------------------------------------
// Bus and FIFO protocol assertions bound into the register top level
// Single-cycle ack, no ack before init, no FIFO overrun or underrun
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module qspim_regs_chk (
  input wire logic mclk,
  input wire logic rst_n,
  input wire logic reg_ack,
  input wire logic init_done,
  input wire logic cmd_fifo_wr,
  input wire logic cmd_fifo_full,
  input wire logic res_fifo_rd,
  input wire logic res_fifo_empty
);

  int unsigned fail_cnt = 0;  // Failed assertion count

  // One pulse per request
  a_ack_pulse: assert property (@(posedge mclk) disable iff (!rst_n)
    reg_ack |=> !reg_ack)
    else begin
      $error("reg_ack held high for two cycles");
      fail_cnt++;
    end

  a_ack_init: assert property (@(posedge mclk) disable iff (!rst_n)
    reg_ack |-> init_done)
    else begin
      $error("reg_ack before init_done");
      fail_cnt++;
    end

  // Overrun of the command FIFO
  a_cmd_full: assert property (@(posedge mclk) disable iff (!rst_n)
    cmd_fifo_wr |-> !cmd_fifo_full)
    else begin
      $error("cmd_fifo_wr while cmd_fifo_full");
      fail_cnt++;
    end

  a_res_empty: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd |-> !res_fifo_empty)
    else begin
      $error("res_fifo_rd while res_fifo_empty");
      fail_cnt++;
    end

endmodule

bind qspim_regs qspim_regs_chk u_chk (.*);

`default_nettype wire

/* tb_qspim_regs.sv */
//--------------------------------------------------------------------------
// Directed testbench for the quad-SPI register and control block
// Command and response FIFO models, bus tasks, directed tests, watchdog
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_qspim_regs import qspim_pkg::*;;

  localparam int CYCLE      = 100;
  localparam int DELAY      = 20;     // Cycles per init wait
  localparam int ACK_LIMIT  = 100;    // Cycle limit per access
  localparam int RUN_CYCLES = 2000;   // Whole run

  logic       mclk, rst_n;
  logic       reg_req, reg_we, reg_ack, init_done;
  reg_addr_t  reg_addr;
  reg_be_t    reg_be;
  reg_data_t  reg_wdata, reg_rdata, spi_status, res_fifo_rdata;
  logic       cmd_fifo_full, cmd_fifo_empty, cmd_fifo_wr;
  logic       res_fifo_empty, res_fifo_rd;
  cmd_word_t  cmd_fifo_wdata;
  xfer_desc_t m0_desc;
  port_cfg_t  m0_port, m1_port;
  logic       m0_fsm_reset;
  logic [1:0] cs_early, cs_late;
  logic [7:0] spi_clk_div;

  cmd_word_t  cmd_q[$];   // Command FIFO model
  reg_data_t  res_q[$];   // Response FIFO model
  int         errors = 0;
  integer     seed = 32'h7c8b;

  tb_clk_gen #(.PERIOD(CYCLE)) u_clk (.clk(mclk));

  qspim_regs #(.INIT_DELAY(DELAY)) UUT (.*);

  //------------------------------------------------------------------------
  // FIFO models
  //------------------------------------------------------------------------
  always @(posedge mclk) begin
    if (rst_n && cmd_fifo_wr) cmd_q.push_back(cmd_fifo_wdata);
    if (rst_n && res_fifo_rd && res_q.size() > 0) res_q.pop_front();
  end

  // Response flags follow the queue and change off the active edge
  always @(negedge mclk) begin
    res_fifo_empty = (res_q.size() == 0);
    res_fifo_rdata = (res_q.size() > 0) ? res_q[0] : '0;
  end

  //------------------------------------------------------------------------
  // Checks and bus tasks
  //------------------------------------------------------------------------
  task automatic check_val(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic expect_cmd(input string tag, input logic soc, input logic eoc,
                            input reg_data_t payload);
    cmd_word_t w;
    if (cmd_q.size() == 0) begin
      errors++;
      $display("%s: no word was written to the command FIFO", tag);
    end else begin
      w = cmd_q.pop_front();
      check_val({tag, ".soc"}, {31'b0, w.soc}, {31'b0, soc});
      check_val({tag, ".eoc"}, {31'b0, w.eoc}, {31'b0, eoc});
      check_val({tag, ".payload"}, w.payload, payload);
    end
  endtask

  task automatic reg_access(input logic we, input reg_addr_t addr, input reg_be_t be,
                            input reg_data_t wdata, output reg_data_t rdata);
    int waited;
    @(negedge mclk);
    reg_req   = 1'b1;
    reg_we    = we;
    reg_addr  = addr;
    reg_be    = be;
    reg_wdata = wdata;
    waited    = 0;
    while (!reg_ack && waited < ACK_LIMIT) begin
      @(negedge mclk);   // Ack is registered and stable here
      waited++;
    end
    if (!reg_ack) begin
      errors++;
      $display("no reg_ack for access to register %0d", addr);
    end
    rdata   = reg_rdata;
    reg_req = 1'b0;
    reg_we  = 1'b0;
  endtask

  task automatic reg_write(input reg_addr_t addr, input reg_be_t be, input reg_data_t d);
    reg_data_t unused;
    reg_access(1'b1, addr, be, d, unused);
  endtask

  task automatic reg_read(input reg_addr_t addr, output reg_data_t d);
    reg_access(1'b0, addr, 4'hF, '0, d);
  endtask

  // Byte lanes with an enable take the new data
  function automatic reg_data_t merge_bytes(reg_data_t old, reg_data_t d, reg_be_t be);
    reg_data_t r;
    r = old;
    for (int i = 0; i < 4; i++) if (be[i]) r[i*8 +: 8] = d[i*8 +: 8];
    return r;
  endfunction

  //------------------------------------------------------------------------
  // Directed tests
  //------------------------------------------------------------------------
  task automatic test_init();
    int waited;
    xfer_desc_t d;
    waited = 0;
    while (!init_done && waited < 10 * DELAY) begin
      @(negedge mclk);
      waited++;
    end
    if (!init_done) begin
      errors++;
      $display("init_done did not rise after the init sequence");
    end
    d = '{data_cnt: 8'd0, dummy_cnt: BITS_8, addr_cnt: BITS_8, seq: SEQ_C,
          mode: 8'h00, cmd: 8'hAB};
    expect_cmd("res_hdr", 1'b1, 1'b1, d);
    d.cmd = 8'h06;
    expect_cmd("wren_hdr", 1'b1, 1'b1, d);
    d = '{data_cnt: 8'd2, dummy_cnt: BITS_8, addr_cnt: BITS_8, seq: SEQ_CW,
          mode: 8'h00, cmd: 8'h01};
    expect_cmd("wrr_hdr", 1'b1, 1'b0, d);
    expect_cmd("wrr_data", 1'b0, 1'b1, 32'h0000_0200);
    check_val("init cmd words left", reg_data_t'(cmd_q.size()), 32'd0);
  endtask

  task automatic test_regs();
    reg_data_t  rd, d, old;
    reg_be_t    be;
    xfer_desc_t desc;
    reg_read(GLBL_CTRL, rd);
    check_val("glbl_ctrl", rd, 32'h0000_0205);    // Div 2, cs_late 1, cs_early 1
    reg_read(DMEM_CTRL1, rd);
    check_val("dmem_ctrl1", rd, {24'h0, 2'd1, 2'd2, 4'b0001});
    // IMEM_CTRL2 still holds the WRR init descriptor
    desc = '{data_cnt: 8'd2, dummy_cnt: BITS_8, addr_cnt: BITS_8, seq: SEQ_CW,
             mode: 8'h00, cmd: 8'h01};
    reg_read(IMEM_CTRL2, rd);
    check_val("imem_ctrl2", rd, desc);
    desc = '{data_cnt: 8'd32, dummy_cnt: BITS_16, addr_cnt: BITS_24, seq: SEQ_CAMDR,
             mode: 8'h00, cmd: 8'hEB};
    reg_read(DMEM_CTRL2, rd);
    check_val("dmem_ctrl2", rd, desc);
    // Configuration outputs towards the SPI engines
    check_val("m0_desc", m0_desc, desc);
    check_val("m0_port", {24'h0, m0_port}, {24'h0, 2'd1, 2'd2, 4'b0001});
    check_val("m0_fsm_reset", {31'b0, m0_fsm_reset}, 32'd0);
    check_val("m1_port", {26'h0, m1_port.mode, m1_port.cs}, {26'h0, 2'd0, 4'b0001});
    check_val("cs_early", {30'b0, cs_early}, 32'd1);
    check_val("cs_late", {30'b0, cs_late}, 32'd1);
    check_val("spi_clk_div", {24'h0, spi_clk_div}, 32'd2);
    // Partial byte writes
    old = 32'h0000_0205;
    d   = $random(seed);
    be  = 4'b0011;
    reg_write(GLBL_CTRL, be, d);
    reg_read(GLBL_CTRL, rd);
    check_val("glbl_ctrl merge", rd, merge_bytes(old, d, be) & 32'h0000_FF0F);
    old = desc;
    d   = $random(seed);
    be  = 4'b1010;
    reg_write(DMEM_CTRL2, be, d);
    reg_read(DMEM_CTRL2, rd);
    check_val("dmem_ctrl2 merge", rd, merge_bytes(old, d, be));
    old = $random(seed);
    reg_write(IMEM_ADDR, 4'hF, old);
    d  = $random(seed);
    be = 4'b0101;
    reg_write(IMEM_ADDR, be, d);
    reg_read(IMEM_ADDR, rd);
    check_val("imem_addr merge", rd, merge_bytes(old, d, be));
    spi_status = $random(seed);
    reg_read(SPI_STATUS, rd);
    check_val("spi_status", rd, spi_status);
  endtask

  task automatic test_ind_write();
    xfer_desc_t desc;
    reg_data_t  addr, d1, d2;
    desc = '{data_cnt: 8'd8, dummy_cnt: BITS_8, addr_cnt: BITS_24, seq: SEQ_CAW,
             mode: 8'h00, cmd: 8'h02};
    addr = $random(seed);
    d1   = $random(seed);
    d2   = $random(seed);
    reg_write(IMEM_CTRL2, 4'hF, desc);
    reg_write(IMEM_ADDR, 4'hF, addr);
    cmd_q.delete();
    reg_write(IMEM_WDATA, 4'hF, d1);
    reg_write(IMEM_WDATA, 4'hF, d2);
    expect_cmd("wr_hdr", 1'b1, 1'b0, desc);
    expect_cmd("wr_addr", 1'b0, 1'b0, addr);
    expect_cmd("wr_data1", 1'b0, 1'b0, d1);
    expect_cmd("wr_data2", 1'b0, 1'b1, d2);
  endtask

  task automatic test_ind_read();
    xfer_desc_t desc;
    reg_data_t  addr, r1, r2, rd;
    desc = '{data_cnt: 8'd8, dummy_cnt: BITS_8, addr_cnt: BITS_24, seq: SEQ_CAR,
             mode: 8'h00, cmd: 8'h03};
    addr = $random(seed);
    r1   = $random(seed);
    r2   = $random(seed);
    reg_write(IMEM_CTRL2, 4'hF, desc);
    reg_write(IMEM_ADDR, 4'hF, addr);
    res_q.push_back(r1);
    res_q.push_back(r2);
    cmd_q.delete();
    @(negedge mclk);                // Flags settle before the read
    reg_read(IMEM_RDATA, rd);
    check_val("rd_data1", rd, r1);
    reg_read(IMEM_RDATA, rd);
    check_val("rd_data2", rd, r2);
    expect_cmd("rd_hdr", 1'b1, 1'b0, desc);
    expect_cmd("rd_addr", 1'b0, 1'b1, addr);
  endtask

  task automatic test_backpressure();
    xfer_desc_t desc;
    reg_data_t  addr, d;
    int         waited;
    desc = '{data_cnt: 8'd4, dummy_cnt: BITS_8, addr_cnt: BITS_24, seq: SEQ_CAW,
             mode: 8'h00, cmd: 8'h32};
    addr = $random(seed);
    d    = $random(seed);
    reg_write(IMEM_CTRL2, 4'hF, desc);
    reg_write(IMEM_ADDR, 4'hF, addr);
    cmd_q.delete();
    @(negedge mclk);
    cmd_fifo_full = 1'b1;
    reg_req   = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = IMEM_WDATA;
    reg_be    = 4'hF;
    reg_wdata = d;
    repeat (10) begin
      @(negedge mclk);
      check_val("reg_ack while full", {31'b0, reg_ack}, 32'd0);
      check_val("cmd words while full", reg_data_t'(cmd_q.size()), 32'd0);
    end
    cmd_fifo_full = 1'b0;
    waited = 0;
    while (!reg_ack && waited < ACK_LIMIT) begin
      @(negedge mclk);
      waited++;
    end
    if (!reg_ack) begin
      errors++;
      $display("no reg_ack after cmd_fifo_full was released");
    end
    reg_req = 1'b0;
    reg_we  = 1'b0;
    expect_cmd("bp_hdr", 1'b1, 1'b0, desc);
    expect_cmd("bp_addr", 1'b0, 1'b0, addr);
    expect_cmd("bp_data", 1'b0, 1'b1, d);
  endtask

  task automatic test_soft_reset();
    xfer_desc_t desc;
    reg_data_t  addr, rd;
    desc = '{data_cnt: 8'd8, dummy_cnt: BITS_8, addr_cnt: BITS_24, seq: SEQ_CAW,
             mode: 8'h00, cmd: 8'h02};
    reg_write(IMEM_CTRL2, 4'hF, desc);
    reg_write(IMEM_WDATA, 4'hF, $random(seed));   // First of two data words
    reg_write(IMEM_CTRL1, 4'b0011, 32'h0000_0101);  // Soft reset on, CS0 single
    reg_read(IMEM_CTRL1, rd);
    check_val("imem_ctrl1 reset bit", rd, 32'h0000_0101);
    reg_write(IMEM_CTRL1, 4'b0011, 32'h0000_0001);
    desc = '{data_cnt: 8'd0, dummy_cnt: BITS_8, addr_cnt: BITS_24, seq: SEQ_CA,
             mode: 8'h00, cmd: 8'h20};
    addr = $random(seed);
    reg_write(IMEM_CTRL2, 4'hF, desc);
    reg_write(IMEM_ADDR, 4'hF, addr);
    cmd_q.delete();
    reg_write(IMEM_WDATA, 4'hF, '0);
    expect_cmd("sr_hdr", 1'b1, 1'b0, desc);
    expect_cmd("sr_addr", 1'b0, 1'b1, addr);
  endtask

  //------------------------------------------------------------------------
  // Main sequence and watchdog
  //------------------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    reg_req        = 1'b0;
    reg_we         = 1'b0;
    reg_addr       = '0;
    reg_be         = '0;
    reg_wdata      = '0;
    spi_status     = '0;
    cmd_fifo_full  = 1'b0;
    cmd_fifo_empty = 1'b1;   // Model drains instantly
    res_fifo_empty = 1'b1;
    res_fifo_rdata = '0;
    repeat (10) @(negedge mclk);
    rst_n = 1'b1;
    test_init();
    test_regs();
    test_ind_write();
    test_ind_read();
    test_backpressure();
    test_soft_reset();
    repeat (4) @(negedge mclk);
    errors += UUT.u_chk.fail_cnt;
    $display("errors: %0d", errors);
    if (errors == 0) $display("TEST PASSED");
    else $display("TEST FAILED");
    $finish;
  end

  initial begin
    #(RUN_CYCLES * CYCLE);
    $display("watchdog expired after %0d cycles, run did not complete", RUN_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
qspim_pkg.sv
qspim_init_seq.sv
qspim_cfg_regs.sv
qspim_ind_fsm.sv
qspim_regs.sv
tb_clk_gen.sv
qspim_regs_chk.sv
tb_qspim_regs.sv

/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_qspim_regs
FILELIST   ?= sources.f
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
